//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_csr_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Result: FAILED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src/csr_decode.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  csr_pkg::csr_req_t  req,
    output logic               cmd_valid,
    output csr_pkg::csr_cmd_t  cmd
);
    import csr_pkg::*;

    csr_cmd_t cmd_d;
    logic     num_known;

    // match against the implemented register set
    always_comb begin
        case (req.csr_num)
            `CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA,
            `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3: begin
                num_known = 1'b1;
            end
            default: begin
                num_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        cmd_d.op      = req.op;
        cmd_d.csr_num = req.csr_num;
        cmd_d.wdata   = req.rd_val;
        cmd_d.pc      = req.pc;
        cmd_d.known   = num_known;
        cmd_d.is_csr  = (req.op == CSRRD) || (req.op == CSRWR) || (req.op == CSRXCHG);
        // csrrd never writes, csrxchg takes its mask from rj
        case (req.op)
            CSRWR:   cmd_d.wmask = 32'hffff_ffff;
            CSRXCHG: cmd_d.wmask = req.rj_val;
            default: cmd_d.wmask = 32'h0000_0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            cmd <= cmd_d;
        end
    end

    a_req_op_legal: assert property (
        @(posedge clk) disable iff (reset)
        req_valid |-> (req.op inside {CSRRD, CSRWR, CSRXCHG, ERTN, SYSCALL})
    ) else $error("csr_decode: illegal opcode %0d", req.op);

endmodule

//--- src/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// implemented csr numbers
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033

// field positions
`define CRMD_PLV        1:0
`define CRMD_IE         2
`define PRMD_PPLV       1:0
`define PRMD_PIE        2
`define ECFG_LIE        12:0
`define ESTAT_IS        12:0
`define ESTAT_HWI       9:2
`define ESTAT_ECODE     21:16

// writable bits per register
`define CRMD_WMASK      32'h0000_01ff
`define PRMD_WMASK      32'h0000_0007
`define ECFG_WMASK      32'h0000_1bff
`define ESTAT_WMASK     32'h0000_0003
`define EENTRY_WMASK    32'hffff_ffc0
`define FULL_WMASK      32'hffff_ffff

// estat bits driven by the interrupt lines
`define ESTAT_HWI_BITS  32'h0000_03fc

`define CRMD_RESET      32'h0000_0008

// exception codes
`define ECODE_INT       6'h00
`define ECODE_SYS       6'h0b
`define ECODE_INE       6'h0d
`define ECODE_IPE       6'h0e

`endif

//--- src/csr_excp_ctrl.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_excp_ctrl (
    input  logic                 cmd_valid,
    input  csr_pkg::csr_cmd_t    cmd,
    input  csr_pkg::csr_status_t status,
    output csr_pkg::csr_commit_t commit
);
    import csr_pkg::*;

    logic int_hit;
    logic ipe_hit;
    logic ine_hit;

    // status already reflects every older instruction
    always_comb begin
        int_hit = status.ie && status.int_pend;
        // csr access is kernel only
        ipe_hit = cmd.is_csr && (status.plv == 2'd3);
        ine_hit = cmd.is_csr && !cmd.known;
    end

    // highest priority first
    always_comb begin
        commit.kind  = NORMAL;
        commit.ecode = 6'h00;
        if (cmd_valid) begin
            if (int_hit) begin
                commit.kind  = EXCEPTION;
                commit.ecode = `ECODE_INT;
            end else if (ipe_hit) begin
                commit.kind  = EXCEPTION;
                commit.ecode = `ECODE_IPE;
            end else if (ine_hit) begin
                commit.kind  = EXCEPTION;
                commit.ecode = `ECODE_INE;
            end else if (cmd.op == SYSCALL) begin
                commit.kind  = EXCEPTION;
                commit.ecode = `ECODE_SYS;
            end else if (cmd.op == ERTN) begin
                commit.kind  = ERET;
            end
        end
    end

endmodule

//--- src/csr_pkg.sv
package csr_pkg;

    // instruction classes handled by the unit
    typedef enum logic [2:0] {
        CSRRD   = 3'd0,
        CSRWR   = 3'd1,
        CSRXCHG = 3'd2,
        ERTN    = 3'd3,
        SYSCALL = 3'd4
    } csr_op_e;

    typedef enum logic [1:0] {
        NORMAL    = 2'd0,
        EXCEPTION = 2'd1,
        ERET      = 2'd2
    } commit_kind_e;

    // request as issued by the core
    typedef struct packed {
        csr_op_e     op;
        logic [13:0] csr_num;
        logic [31:0] rj_val;
        logic [31:0] rd_val;
        logic [31:0] pc;
    } csr_req_t;

    // decoded command held in the first pipeline register
    typedef struct packed {
        csr_op_e     op;
        logic [13:0] csr_num;
        logic [31:0] wmask;
        logic [31:0] wdata;
        logic [31:0] pc;
        logic        is_csr;
        // number is one of the implemented csrs
        logic        known;
    } csr_cmd_t;

    typedef struct packed {
        logic [1:0] plv;
        logic       ie;
        logic       int_pend;
    } csr_status_t;

    typedef struct packed {
        commit_kind_e kind;
        logic [5:0]   ecode;
    } csr_commit_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        redirect;
        logic [31:0] redirect_pc;
        logic [5:0]  ecode;
    } csr_resp_t;

endpackage

//--- src/csr_regfile.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [7:0]           hw_int,
    input  logic                 cmd_valid,
    input  csr_pkg::csr_cmd_t    cmd,
    input  csr_pkg::csr_commit_t commit,
    output csr_pkg::csr_status_t status,
    output logic [1:0]           plv,
    output logic                 resp_valid,
    output csr_pkg::csr_resp_t   resp
);
    import csr_pkg::*;

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] ecfg;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] eentry;
    logic [31:0] save0;
    logic [31:0] save1;
    logic [31:0] save2;
    logic [31:0] save3;

    logic [31:0] rd_old;
    logic [31:0] reg_wmask;
    logic [31:0] wr_mask;
    logic [31:0] wr_val;
    logic        take_excp;
    logic        take_ertn;
    logic        wr_normal;

    assign take_excp = cmd_valid && (commit.kind == EXCEPTION);
    assign take_ertn = cmd_valid && (commit.kind == ERET);
    assign wr_normal = cmd_valid && (commit.kind == NORMAL) && cmd.is_csr && cmd.known;

    // old value and writable bits of the addressed csr
    always_comb begin
        case (cmd.csr_num)
            `CSR_CRMD:   begin rd_old = crmd;   reg_wmask = `CRMD_WMASK;   end
            `CSR_PRMD:   begin rd_old = prmd;   reg_wmask = `PRMD_WMASK;   end
            `CSR_ECFG:   begin rd_old = ecfg;   reg_wmask = `ECFG_WMASK;   end
            `CSR_ESTAT:  begin rd_old = estat;  reg_wmask = `ESTAT_WMASK;  end
            `CSR_ERA:    begin rd_old = era;    reg_wmask = `FULL_WMASK;   end
            `CSR_EENTRY: begin rd_old = eentry; reg_wmask = `EENTRY_WMASK; end
            `CSR_SAVE0:  begin rd_old = save0;  reg_wmask = `FULL_WMASK;   end
            `CSR_SAVE1:  begin rd_old = save1;  reg_wmask = `FULL_WMASK;   end
            `CSR_SAVE2:  begin rd_old = save2;  reg_wmask = `FULL_WMASK;   end
            `CSR_SAVE3:  begin rd_old = save3;  reg_wmask = `FULL_WMASK;   end
            default:     begin rd_old = 32'h0;  reg_wmask = 32'h0;         end
        endcase
    end

    assign wr_mask = cmd.wmask & reg_wmask;
    assign wr_val  = (rd_old & ~wr_mask) | (cmd.wdata & wr_mask);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd   <= `CRMD_RESET;
            prmd   <= 32'h0;
            ecfg   <= 32'h0;
            estat  <= 32'h0;
            era    <= 32'h0;
            eentry <= 32'h0;
            save0  <= 32'h0;
            save1  <= 32'h0;
            save2  <= 32'h0;
            save3  <= 32'h0;
        end else begin
            if (take_excp) begin
                prmd[`PRMD_PPLV]   <= crmd[`CRMD_PLV];
                prmd[`PRMD_PIE]    <= crmd[`CRMD_IE];
                crmd[`CRMD_PLV]    <= 2'b00;
                crmd[`CRMD_IE]     <= 1'b0;
                era                <= cmd.pc;
                estat[`ESTAT_ECODE] <= commit.ecode;
            end else if (take_ertn) begin
                crmd[`CRMD_PLV] <= prmd[`PRMD_PPLV];
                crmd[`CRMD_IE]  <= prmd[`PRMD_PIE];
            end else if (wr_normal) begin
                case (cmd.csr_num)
                    `CSR_CRMD:   crmd   <= wr_val;
                    `CSR_PRMD:   prmd   <= wr_val;
                    `CSR_ECFG:   ecfg   <= wr_val;
                    `CSR_ESTAT:  estat  <= wr_val;
                    `CSR_ERA:    era    <= wr_val;
                    `CSR_EENTRY: eentry <= wr_val;
                    `CSR_SAVE0:  save0  <= wr_val;
                    `CSR_SAVE1:  save1  <= wr_val;
                    `CSR_SAVE2:  save2  <= wr_val;
                    `CSR_SAVE3:  save3  <= wr_val;
                    default:     ;
                endcase
            end
            // interrupt lines land in IS[9:2] every cycle
            estat[`ESTAT_HWI] <= hw_int;
        end
    end

    assign plv             = crmd[`CRMD_PLV];
    assign status.plv      = crmd[`CRMD_PLV];
    assign status.ie       = crmd[`CRMD_IE];
    assign status.int_pend = |(estat[`ESTAT_IS] & ecfg[`ECFG_LIE]);

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= cmd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            resp.ecode <= commit.ecode;
            if (take_excp) begin
                resp.rdata       <= 32'h0;
                resp.redirect    <= 1'b1;
                resp.redirect_pc <= eentry;
            end else if (take_ertn) begin
                resp.rdata       <= 32'h0;
                resp.redirect    <= 1'b1;
                resp.redirect_pc <= era;
            end else begin
                resp.rdata       <= rd_old;
                resp.redirect    <= 1'b0;
                resp.redirect_pc <= 32'h0;
            end
        end
    end

    // a plain write only moves writable bits, hw lines may still toggle IS
    a_wmask_held: assert property (
        @(posedge clk) disable iff (reset)
        wr_normal |=>
            (((crmd ^ $past(crmd)) & ~`CRMD_WMASK) == 32'h0) &&
            (((prmd ^ $past(prmd)) & ~`PRMD_WMASK) == 32'h0) &&
            (((ecfg ^ $past(ecfg)) & ~`ECFG_WMASK) == 32'h0) &&
            (((estat ^ $past(estat)) & ~(`ESTAT_WMASK | `ESTAT_HWI_BITS)) == 32'h0) &&
            (((eentry ^ $past(eentry)) & ~`EENTRY_WMASK) == 32'h0)
    ) else $error("csr_regfile: read-only csr bits changed on a write");

endmodule

//--- src/csr_top.sv
`timescale 1ns/1ps

module csr_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  csr_pkg::csr_req_t  req,
    input  logic [7:0]         hw_int,
    output logic               resp_valid,
    output csr_pkg::csr_resp_t resp,
    output logic [1:0]         plv
);
    import csr_pkg::*;

    logic        cmd_valid;
    csr_cmd_t    cmd;
    csr_status_t status;
    csr_commit_t commit;

    // stage one
    csr_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    // stage two check, beside the commit
    csr_excp_ctrl u_excp_ctrl (
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .status    (status),
        .commit    (commit)
    );

    csr_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .hw_int     (hw_int),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .commit     (commit),
        .status     (status),
        .plv        (plv),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

//--- tb/csr_ref_model.svh
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// slot order crmd prmd ecfg estat era eentry save0..save3
localparam logic [13:0] model_nums [10] = '{
    `CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA,
    `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3
};

// writable bits per slot
localparam logic [31:0] model_masks [10] = '{
    32'h0000_01ff, 32'h0000_0007, 32'h0000_1bff, 32'h0000_0003, 32'hffff_ffff,
    32'hffff_ffc0, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff
};

logic [31:0] m_csr [10];

function automatic void model_reset();
    for (int i = 0; i < 10; i++) begin
        m_csr[i] = 32'h0;
    end
    // DA set, plv 0, interrupts off
    m_csr[0] = 32'h0000_0008;
endfunction

// -1 for a number outside the implemented set
function automatic int model_slot(input logic [13:0] num);
    for (int i = 0; i < 10; i++) begin
        if (model_nums[i] == num) begin
            return i;
        end
    end
    return -1;
endfunction

// applies one instruction in order and returns its response
function automatic csr_resp_t model_step(input csr_req_t r, input logic [7:0] hw);
    csr_resp_t   e;
    int          s;
    logic        is_csr;
    logic        take;
    logic [5:0]  code;
    logic [31:0] m;
    s = model_slot(r.csr_num);
    is_csr = r.op inside {CSRRD, CSRWR, CSRXCHG};
    m_csr[3][9:2] = hw;
    e = '0;
    take = 1'b1;
    code = 6'h00;
    if (m_csr[0][2] && ((m_csr[3][12:0] & m_csr[2][12:0]) != 13'h0)) begin
        code = `ECODE_INT;
    end else if (is_csr && (m_csr[0][1:0] == 2'd3)) begin
        code = `ECODE_IPE;
    end else if (is_csr && (s < 0)) begin
        code = `ECODE_INE;
    end else if (r.op == SYSCALL) begin
        code = `ECODE_SYS;
    end else begin
        take = 1'b0;
    end
    if (take) begin
        // plv and ie move to prmd together
        m_csr[1][2:0] = m_csr[0][2:0];
        m_csr[0][2:0] = 3'b000;
        m_csr[4] = r.pc;
        m_csr[3][21:16] = code;
        e.redirect = 1'b1;
        e.redirect_pc = m_csr[5];
        e.ecode = code;
    end else if (r.op == ERTN) begin
        m_csr[0][2:0] = m_csr[1][2:0];
        e.redirect = 1'b1;
        e.redirect_pc = m_csr[4];
    end else begin
        m = (r.op == CSRWR) ? 32'hffff_ffff : ((r.op == CSRXCHG) ? r.rj_val : 32'h0);
        m = m & model_masks[s];
        e.rdata = m_csr[s];
        m_csr[s] = (m_csr[s] & ~m) | (r.rd_val & m);
    end
    return e;
endfunction

`endif

//--- tb/tb_csr_top.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module tb_csr_top;
    import csr_pkg::*;

    logic       clk;
    logic       reset;
    logic       req_valid;
    csr_req_t   req;
    logic [7:0] hw_int;
    logic       resp_valid;
    csr_resp_t  resp;
    logic [1:0] plv;

    logic [31:0] lfsr = 32'h8977_6a21;
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_start;
    csr_resp_t   exp_q [$];
    int          sent_q [$];
    csr_resp_t   exp_resp;
    int          sent_cycle;

    `include "csr_ref_model.svh"

    csr_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .hw_int     (hw_int),
        .resp_valid (resp_valid),
        .resp       (resp),
        .plv        (plv)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expv);
        checks++;
        if (got !== expv) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, expv);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%0t %s", $time, why);
        $display("Result: FAILED");
        $finish;
    endtask

    function automatic csr_req_t make_req(input csr_op_e op, input logic [13:0] num,
                                          input logic [31:0] rj, input logic [31:0] rd);
        csr_req_t    r;
        logic [31:0] pc;
        pc = lfsr_bits(30);
        r.op = op;
        r.csr_num = num;
        r.rj_val = rj;
        r.rd_val = rd;
        r.pc = {pc[29:0], 2'b00};
        return r;
    endfunction

    // expected response is taken from the model as the request goes out
    task automatic issue(input csr_req_t r);
        @(negedge clk);
        req_valid = 1'b1;
        req = r;
        exp_q.push_back(model_step(r, hw_int));
        sent_q.push_back(cycle);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    task automatic set_hw(input logic [7:0] v);
        idle(2);
        hw_int = v;
        idle(2);
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((exp_q.size() != 0) && (n < limit)) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            abort_run($sformatf("timeout, %0d responses never arrived", exp_q.size()));
        end
    endtask

    task automatic finish_test(input string name);
        idle(1);
        wait_drain(20);
        check_val("plv", {30'h0, plv}, {30'h0, m_csr[0][1:0]});
        tests++;
        $display("test %-10s %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    // responses are sampled on the falling edge, away from the update edge
    always @(negedge clk) begin
        if (!reset && resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("%0t response arrived with no request outstanding", $time);
                errors++;
            end else begin
                exp_resp = exp_q.pop_front();
                sent_cycle = sent_q.pop_front();
                check_val("resp.rdata", resp.rdata, exp_resp.rdata);
                check_val("resp.redirect", {31'h0, resp.redirect}, {31'h0, exp_resp.redirect});
                check_val("resp.redirect_pc", resp.redirect_pc, exp_resp.redirect_pc);
                check_val("resp.ecode", {26'h0, resp.ecode}, {26'h0, exp_resp.ecode});
                check_val("latency", cycle - sent_cycle, 32'd2);
            end
        end
    end

    initial begin
        logic [31:0] bits;
        logic [13:0] num;
        csr_op_e     op;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        hw_int = 8'h00;
        model_reset();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_start = 0;

        for (int i = 0; i < 10; i++) begin
            issue(make_req(CSRRD, model_nums[i], 32'h0, 32'h0));
        end
        check_val("plv", {30'h0, plv}, 32'h0);
        finish_test("reset");

        // crmd left alone so plv stays 0
        for (int i = 0; i < 60; i++) begin
            bits = lfsr_bits(4);
            num = model_nums[1 + (bits % 9)];
            bits = lfsr_bits(1);
            op = bits[0] ? CSRXCHG : CSRWR;
            issue(make_req(op, num, lfsr_bits(32), lfsr_bits(32)));
            issue(make_req(CSRRD, num, 32'h0, 32'h0));
        end
        finish_test("masked");

        issue(make_req(CSRWR, `CSR_ECFG, 32'h0, 32'h0));
        issue(make_req(CSRWR, `CSR_EENTRY, 32'h0, 32'h1c00_8000));
        issue(make_req(CSRWR, `CSR_CRMD, 32'h0, 32'h0000_000c));
        issue(make_req(SYSCALL, 14'h0, 32'h0, 32'h0));
        issue(make_req(CSRRD, `CSR_ERA, 32'h0, 32'h0));
        issue(make_req(CSRRD, `CSR_PRMD, 32'h0, 32'h0));
        issue(make_req(CSRRD, `CSR_ESTAT, 32'h0, 32'h0));
        issue(make_req(ERTN, 14'h0, 32'h0, 32'h0));
        issue(make_req(CSRRD, `CSR_CRMD, 32'h0, 32'h0));
        finish_test("exception");

        issue(make_req(CSRRD, 14'h3ff, 32'h0, 32'h0));
        issue(make_req(CSRWR, `CSR_PRMD, 32'h0, 32'h0000_0003));
        issue(make_req(ERTN, 14'h0, 32'h0, 32'h0));
        idle(1);
        wait_drain(20);
        check_val("plv", {30'h0, plv}, 32'h3);
        issue(make_req(CSRRD, `CSR_SAVE0, 32'h0, 32'h0));
        finish_test("illegal");

        // line 0 lands on IS bit 2
        issue(make_req(CSRWR, `CSR_ECFG, 32'h0, 32'h0000_0004));
        issue(make_req(CSRWR, `CSR_CRMD, 32'h0, 32'h0000_000c));
        set_hw(8'h01);
        issue(make_req(CSRRD, `CSR_SAVE1, 32'h0, 32'h0));
        issue(make_req(CSRRD, `CSR_SAVE1, 32'h0, 32'h0));
        issue(make_req(CSRRD, `CSR_ESTAT, 32'h0, 32'h0));
        set_hw(8'h00);
        finish_test("interrupt");

        bits = lfsr_bits(8);
        set_hw(bits[7:0]);
        for (int i = 0; i < 400; i++) begin
            bits = lfsr_bits(4);
            if (bits < 10) begin
                num = model_nums[bits];
            end else begin
                bits = lfsr_bits(14);
                num = bits[13:0];
            end
            bits = lfsr_bits(3);
            case (bits[2:0])
                3'd0, 3'd1: op = CSRRD;
                3'd2, 3'd3: op = CSRWR;
                3'd4, 3'd5: op = CSRXCHG;
                3'd6:       op = ERTN;
                default:    op = SYSCALL;
            endcase
            issue(make_req(op, num, lfsr_bits(32), lfsr_bits(32)));
        end
        finish_test("random");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+src
+incdir+tb
src/csr_pkg.sv
src/csr_decode.sv
src/csr_excp_ctrl.sv
src/csr_regfile.sv
src/csr_top.sv
tb/tb_csr_top.sv
